//--- cpu_bus_decoder.sv
// cpu bus decoder of the peripheral page
// access FSM, ack timing, data-table port and read-data mux
`timescale 1ns/1ps
`default_nettype none
`include "mcu_periph_macros.svh"

module cpu_bus_decoder
	import mcu_periph_pkg::*;
(
	input  wire                      clk_sys,
	input  wire                      reset_n,
	// cpu bus
	input  wire                      cpu_req,
	input  wire word_t               cpu_addr,     // held by the master until ack
	input  wire word_t               cpu_wdata,
	input  wire [3:0]                cpu_wstrb,    // nonzero means write
	output logic                     cpu_ack,
	output word_t                    cpu_rdata,
	// data-table RAM, registered read
	output logic [`MCU_TABLE_AW-1:0] datatable_addr,
	output logic                     datatable_wren,
	output word_t                    datatable_data,
	input  wire word_t               datatable_q,
	// function blocks
	output reg_sel_e                 reg_sel,
	output logic                     wr_stb,
	output word_t                    wr_data,
	input  wire word_t               slot_rd_data,
	input  wire word_t               timer_rd_data,
	input  wire word_t               io_rd_data
);

	bus_state_e state;
	reg_sel_e   sel_next;   // decode of the live address
	logic       wr_q;       // access is a write
	word_t      rd_mux;

	// page and offset decode
	always_comb begin
		sel_next = sel_none; // unmapped offsets read zero
		if (cpu_addr[31:16] != `MCU_PERIPH_PAGE) begin
			sel_next = sel_outside; // program RAM space, answered with zero
		end else if (cpu_addr[15:12] == 4'h0) begin
			sel_next = sel_table;
		end else begin
			case (cpu_addr[15:0])
				`MCU_REG_SLOT_ID:     sel_next = sel_slot_id;
				`MCU_REG_SLOT_BRIDGE: sel_next = sel_slot_bridge;
				`MCU_REG_SLOT_LEN:    sel_next = sel_slot_len;
				`MCU_REG_SLOT_OFFS:   sel_next = sel_slot_offs;
				`MCU_REG_SLOT_CTRL:   sel_next = sel_slot_ctrl;
				`MCU_REG_SYSCLK:      sel_next = sel_sysclk;
				`MCU_REG_RESET:       sel_next = sel_reset;
				`MCU_REG_TIMER:       sel_next = sel_timer;
				`MCU_REG_IO_CTRL:     sel_next = sel_io_ctrl;
				`MCU_REG_IO_STAT:     sel_next = sel_io_stat;
				default:              sel_next = sel_none;
			endcase
		end
	end

	assign wr_stb  = (state == bus_decode) && wr_q; // one cycle per write
	assign wr_data = cpu_wdata;
	assign cpu_ack = (state == bus_ack);

	// table port straight off the held address
	assign datatable_addr = cpu_addr[`MCU_TABLE_AW+1:2];
	assign datatable_data = cpu_wdata;
	assign datatable_wren = wr_stb && (reg_sel == sel_table);

	// block read data, all combinational from reg_sel
	always_comb begin
		case (reg_sel)
			sel_slot_id, sel_slot_bridge, sel_slot_len, sel_slot_offs,
			sel_slot_ctrl, sel_reset:  rd_mux = slot_rd_data;
			sel_sysclk, sel_timer:     rd_mux = timer_rd_data;
			sel_io_ctrl, sel_io_stat:  rd_mux = io_rd_data;
			default:                   rd_mux = '0; // table comes later, outside is zero
		endcase
	end

	// access sequencing
	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			state   <= bus_idle;
			reg_sel <= sel_none;
			wr_q    <= 1'b0;
		end else begin
			case (state)
				bus_idle: begin
					if (cpu_req) begin
						reg_sel <= sel_next;
						wr_q    <= |cpu_wstrb;
						state   <= bus_decode;
					end
				end
				bus_decode: begin
					// only table reads wait for the RAM
					if (reg_sel == sel_table && !wr_q)
						state <= bus_ram_wait;
					else
						state <= bus_ack;
				end
				bus_ram_wait: state <= bus_ack;
				bus_ack: begin
					state   <= bus_idle; // master drops req next cycle
					reg_sel <= sel_none;
					wr_q    <= 1'b0;
				end
				default: state <= bus_idle;
			endcase
		end
	end

	// read data for the ack cycle
	always_ff @(posedge clk_sys) begin
		if (state == bus_decode)
			cpu_rdata <= rd_mux;
		else if (state == bus_ram_wait)
			cpu_rdata <= datatable_q; // RAM q valid one cycle after address
	end

endmodule

`default_nettype wire

//--- dataslot_regs.sv
// target dataslot command registers and reset_out
// parameter regs, read/write command pulses, status readback
`timescale 1ns/1ps
`default_nettype none
`include "mcu_periph_macros.svh"

module dataslot_regs
	import mcu_periph_pkg::*;
(
	input  wire            clk_sys,
	input  wire            reset_n,
	input  wire reg_sel_e  reg_sel,
	input  wire            wr_stb,
	input  wire word_t     wr_data,
	// status from the APF side
	input  wire            target_dataslot_ack,  // high from command start to completion
	input  wire            target_dataslot_done, // high from finish to next command
	input  wire slot_err_t target_dataslot_err,
	// command parameters
	output slot_id_t       target_dataslot_id,
	output word_t          target_dataslot_bridgeaddr,
	output word_t          target_dataslot_length,
	output word_t          target_dataslot_slotoffset,
	output logic           target_dataslot_read,
	output logic           target_dataslot_write,
	output logic           reset_out,
	output word_t          rd_data
);

	// parameters, set before a command is issued
	always_ff @(posedge clk_sys) begin
		if (wr_stb) begin
			case (reg_sel)
				sel_slot_id:     target_dataslot_id         <= slot_id_t'(wr_data);
				sel_slot_bridge: target_dataslot_bridgeaddr <= wr_data; // where in bridge space
				sel_slot_len:    target_dataslot_length     <= wr_data;
				sel_slot_offs:   target_dataslot_slotoffset <= wr_data;
				default: ;
			endcase
		end
	end

	// command pulses and reset_out
	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			target_dataslot_read  <= 1'b0;
			target_dataslot_write <= 1'b0;
			reset_out             <= 1'b0;
		end else begin
			target_dataslot_read  <= 1'b0; // single cycle
			target_dataslot_write <= 1'b0;
			if (wr_stb && reg_sel == sel_slot_ctrl) begin
				target_dataslot_read  <= wr_data[0];
				target_dataslot_write <= wr_data[1];
			end
			if (wr_stb && reg_sel == sel_reset)
				reset_out <= wr_data[0];
		end
	end

	always_comb begin
		case (reg_sel)
			sel_slot_id:
				rd_data = {{(`MCU_WORD_W-$bits(slot_id_t)){1'b0}}, target_dataslot_id};
			sel_slot_bridge: rd_data = target_dataslot_bridgeaddr;
			sel_slot_len:    rd_data = target_dataslot_length;
			sel_slot_offs:   rd_data = target_dataslot_slotoffset;
			sel_slot_ctrl:   // live status, not the last write
				rd_data = {{(`MCU_WORD_W-5){1'b0}}, target_dataslot_ack,
					target_dataslot_done, target_dataslot_err};
			sel_reset:       rd_data = {{(`MCU_WORD_W-1){1'b0}}, reset_out};
			default:         rd_data = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- hps_io_port.sv
// HPS IO port
// control register, select decode, strobe/ack handshake with the core
`timescale 1ns/1ps
`default_nettype none
`include "mcu_periph_macros.svh"

module hps_io_port
	import mcu_periph_pkg::*;
(
	input  wire           clk_sys,
	input  wire           reset_n,
	input  wire reg_sel_e reg_sel,
	input  wire           wr_stb,
	input  wire word_t    wr_data,
	input  wire           io_wait,   // core not ready, holds rack
	input  wire io_data_t io_din,
	input  wire           io_wide,
	output logic          io_uio,
	output logic          io_fpga,
	output logic          io_strobe,
	output io_data_t      io_dout,
	output word_t         rd_data
);

	logic io_clk;  // transfer clock from the cpu
	logic io_ss0;
	logic io_ss1;
	logic io_ss2;
	logic rack;    // io_clk seen by the core
	logic io_ack;  // transfer done

	assign io_fpga   = io_ss0 & ~io_ss1; // commands to the FPGA side
	assign io_uio    = io_ss2 & ~io_ss1; // broadcast access
	assign io_strobe = io_clk & ~rack;   // edge of io_clk until it is taken

	always_ff @(posedge clk_sys) begin
		if (wr_stb && reg_sel == sel_io_ctrl)
			io_dout <= wr_data[15:0];
	end

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			io_clk <= 1'b0;
			io_ss0 <= 1'b0;
			io_ss1 <= 1'b0;
			io_ss2 <= 1'b0;
			rack   <= 1'b0;
			io_ack <= 1'b0;
		end else begin
			if (wr_stb && reg_sel == sel_io_ctrl) begin
				io_clk <= wr_data[`MCU_IO_CLK_BIT];
				io_ss0 <= wr_data[`MCU_IO_SS0_BIT];
				io_ss1 <= wr_data[`MCU_IO_SS1_BIT];
				io_ss2 <= wr_data[`MCU_IO_SS2_BIT];
			end
			// pipeline frozen while the core waits, strobe still gets through
			if (!io_wait || io_strobe) begin
				rack   <= io_clk;
				io_ack <= rack;
			end
		end
	end

	always_comb begin
		rd_data = '0;
		case (reg_sel)
			sel_io_ctrl: begin
				rd_data[15:0]                = io_dout;
				rd_data[`MCU_IO_CLK_BIT]     = io_clk;
				rd_data[`MCU_IO_SS0_BIT]     = io_ss0;
				rd_data[`MCU_IO_SS1_BIT]     = io_ss1;
				rd_data[`MCU_IO_SS2_BIT]     = io_ss2;
			end
			sel_io_stat: rd_data = {{(`MCU_WORD_W-18){1'b0}}, io_ack, io_wide, io_din};
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- mcu_periph.f
+incdir+.
mcu_periph_pkg.sv
cpu_bus_decoder.sv
dataslot_regs.sv
ms_timer.sv
hps_io_port.sv
mcu_periph_top.sv
tb_mcu_periph.sv

//--- mcu_periph_macros.svh
// register offsets and widths of the peripheral page
// bus word, data-table window and HPS IO control bit positions
`ifndef MCU_PERIPH_MACROS_SVH
`define MCU_PERIPH_MACROS_SVH

`define MCU_WORD_W          32        // cpu bus word
`define MCU_PERIPH_PAGE     16'hFFFF  // upper address half of the peripheral page
`define MCU_TABLE_AW        10        // data-table word address, 4 KB window

// target dataslot command block
`define MCU_REG_SLOT_ID     16'hFF80
`define MCU_REG_SLOT_BRIDGE 16'hFF84
`define MCU_REG_SLOT_LEN    16'hFF88
`define MCU_REG_SLOT_OFFS   16'hFF8C
`define MCU_REG_SLOT_CTRL   16'hFF90  // w: command pulses, r: live status

`define MCU_REG_SYSCLK      16'hFF98  // ms tick divisor
`define MCU_REG_RESET       16'hFFA4  // reset_out in bit 0
`define MCU_REG_TIMER       16'hFFC8  // ms count, write bit 0 to clear

// HPS IO port
`define MCU_REG_IO_CTRL     16'hFFD0
`define MCU_REG_IO_STAT     16'hFFD4

`define MCU_IO_CLK_BIT      17
`define MCU_IO_SS0_BIT      18
`define MCU_IO_SS1_BIT      19
`define MCU_IO_SS2_BIT      20

`endif

//--- mcu_periph_pkg.sv
// shared types of the peripheral block
// word and field types, access select and bus FSM enums
`default_nettype none
`include "mcu_periph_macros.svh"

package mcu_periph_pkg;

	typedef logic [`MCU_WORD_W-1:0] word_t;   // one bus word
	typedef logic [15:0]            slot_id_t; // dataslot id
	typedef logic [15:0]            io_data_t; // HPS data word
	typedef logic [2:0]             slot_err_t; // command result, zero is ok

	// decoded target, the opcode of an access
	typedef enum logic [3:0] {
		sel_none,        // unmapped peripheral offset
		sel_table,
		sel_slot_id,
		sel_slot_bridge,
		sel_slot_len,
		sel_slot_offs,
		sel_slot_ctrl,
		sel_sysclk,
		sel_reset,
		sel_timer,
		sel_io_ctrl,
		sel_io_stat,
		sel_outside      // not in the peripheral page
	} reg_sel_e;

	typedef enum logic [1:0] {
		bus_idle,
		bus_decode,      // writes land at the end of this cycle
		bus_ram_wait,    // table read, RAM output registered
		bus_ack
	} bus_state_e;

endpackage

`default_nettype wire

//--- mcu_periph_top.sv
// peripheral block top level
// cpu bus decoder driving dataslot, timer and HPS IO blocks
`timescale 1ns/1ps
`default_nettype none
`include "mcu_periph_macros.svh"

module mcu_periph_top
	import mcu_periph_pkg::*;
(
	input  wire                      clk_sys,
	input  wire                      reset_n,
	// cpu bus
	input  wire                      cpu_req,
	input  wire word_t               cpu_addr,
	input  wire word_t               cpu_wdata,
	input  wire [3:0]                cpu_wstrb,
	output logic                     cpu_ack,
	output word_t                    cpu_rdata,
	output logic                     reset_out,
	// target dataslot
	output logic                     target_dataslot_read,
	output logic                     target_dataslot_write,
	input  wire                      target_dataslot_ack,
	input  wire                      target_dataslot_done,
	input  wire slot_err_t           target_dataslot_err,
	output slot_id_t                 target_dataslot_id,
	output word_t                    target_dataslot_bridgeaddr,
	output word_t                    target_dataslot_length,
	output word_t                    target_dataslot_slotoffset,
	// data-table RAM
	output logic [`MCU_TABLE_AW-1:0] datatable_addr,
	output logic                     datatable_wren,
	output word_t                    datatable_data,
	input  wire word_t               datatable_q,
	// HPS IO
	output logic                     io_uio,
	output logic                     io_fpga,
	output logic                     io_strobe,
	input  wire                      io_wait,
	input  wire io_data_t            io_din,
	output io_data_t                 io_dout,
	input  wire                      io_wide       // 1 = 16 bit, 0 = 8 bit
);

	reg_sel_e reg_sel;       // latched target of the current access
	logic     wr_stb;
	word_t    wr_data;
	word_t    slot_rd_data;  // each block returns zero outside its selects
	word_t    timer_rd_data;
	word_t    io_rd_data;

	cpu_bus_decoder u_decoder (.*);

	dataslot_regs u_slot (.rd_data(slot_rd_data), .*);

	ms_timer u_timer (.rd_data(timer_rd_data), .*);

	hps_io_port u_io (.rd_data(io_rd_data), .*);

endmodule

`default_nettype wire

//--- ms_timer.sv
// millisecond timer
// tick divisor register, tick prescaler and ms counter
`timescale 1ns/1ps
`default_nettype none
`include "mcu_periph_macros.svh"

module ms_timer
	import mcu_periph_pkg::*;
(
	input  wire           clk_sys,
	input  wire           reset_n,
	input  wire reg_sel_e reg_sel,
	input  wire           wr_stb,
	input  wire word_t    wr_data,
	output word_t         rd_data
);

	localparam int TICK_W = 20; // prescaler width

	word_t             sysclk_div;        // last tick value, period is div+1
	logic [TICK_W-1:0] tick_count;
	word_t             millisecond_count;
	logic              tick_wrap;

	assign tick_wrap = ({{(`MCU_WORD_W-TICK_W){1'b0}}, tick_count} == sysclk_div);

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			sysclk_div        <= '0;
			tick_count        <= '0;
			millisecond_count <= '0;
		end else begin
			if (wr_stb && reg_sel == sel_sysclk)
				sysclk_div <= wr_data;
			if (wr_stb && reg_sel == sel_timer && wr_data[0]) begin
				tick_count        <= '0; // synchronous clear of both
				millisecond_count <= '0;
			end else if (tick_wrap) begin
				tick_count        <= '0;
				millisecond_count <= millisecond_count + 1'b1;
			end else begin
				tick_count <= tick_count + 1'b1;
			end
		end
	end

	always_comb begin
		case (reg_sel)
			sel_sysclk: rd_data = sysclk_div;
			sel_timer:  rd_data = millisecond_count;
			default:    rd_data = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, then decide from the simulation log
rm -f sim.log
verilator --binary --top-module tb_mcu_periph -f mcu_periph.f > build.log 2>&1 \
	&& ./obj_dir/Vtb_mcu_periph > sim.log 2>&1 \
	|| { echo "build or run error, see build.log and sim.log"; exit 1; }
grep -q "Simulation failed" sim.log \
	&& { echo "FAIL"; exit 1; } \
	|| { grep -q "Simulation passed" sim.log && echo "PASS" && exit 0; }
echo "FAIL, no result in sim.log"
exit 1

//--- tb_mcu_periph.sv
// testbench of the peripheral block
// clock, reset, bus tasks, RAM and io_wait models, reference model, checks and tests
`timescale 1ns/1ps
`default_nettype none
`include "mcu_periph_macros.svh"

module tb_mcu_periph
	import mcu_periph_pkg::*;
();

	localparam int ACK_TIMEOUT = 16;  // cycles per bus access
	localparam int IO_TIMEOUT  = 40;  // status polls

	logic                     clk_sys = 1'b0;
	logic                     reset_n;
	logic                     cpu_req;
	word_t                    cpu_addr;
	word_t                    cpu_wdata;
	logic [3:0]               cpu_wstrb;
	logic                     cpu_ack;
	word_t                    cpu_rdata;
	logic                     reset_out;
	logic                     target_dataslot_read;
	logic                     target_dataslot_write;
	logic                     target_dataslot_ack;
	logic                     target_dataslot_done;
	slot_err_t                target_dataslot_err;
	slot_id_t                 target_dataslot_id;
	word_t                    target_dataslot_bridgeaddr;
	word_t                    target_dataslot_length;
	word_t                    target_dataslot_slotoffset;
	logic [`MCU_TABLE_AW-1:0] datatable_addr;
	logic                     datatable_wren;
	word_t                    datatable_data;
	word_t                    datatable_q = '0;
	logic                     io_uio;
	logic                     io_fpga;
	logic                     io_strobe;
	logic                     io_wait = 1'b0;
	io_data_t                 io_din;
	io_data_t                 io_dout;
	logic                     io_wide;

	integer     seed = 8;
	int         errors = 0;
	int         checks = 0;
	int         tests = 0;
	int         cycle = 0;      // free running, for timer gaps
	int         ack_cycle;      // cycle of the last ack
	int         rd_pulses = 0;
	int         wr_pulses = 0;
	int         strobes = 0;
	logic       cmp_en = 1'b0;  // current read goes through the reference
	logic       wait_hold = 1'b0;
	logic       exp_io_ack = 1'b0;
	word_t      ram [0:1023];   // data-table RAM model
	word_t      shadow_table [0:1023];
	slot_id_t   sh_id;
	word_t      sh_bridge;
	word_t      sh_len;
	word_t      sh_offs;
	word_t      sh_sysclk;
	word_t      sh_io_ctrl;
	logic       sh_reset;
	bus_state_e dbg_state;

	mcu_periph_top dut0 (.*);

	assign dbg_state = dut0.u_decoder.state; // shown on a timeout

	always #2 clk_sys = ~clk_sys;

	always @(posedge clk_sys) cycle <= cycle + 1;

	// registered read, old data on a same-address write
	always @(posedge clk_sys) begin
		if (datatable_wren)
			ram[datatable_addr] <= datatable_data;
		datatable_q <= ram[datatable_addr];
	end

	// core side, busy one cycle in four or held by a test
	always @(posedge clk_sys) io_wait <= wait_hold || (cycle[1:0] == 2'b00);

	function automatic word_t fill_word(input int idx);
		return {6'h2A, idx[9:0], 6'h15, ~idx[9:0]};
	endfunction

	function automatic word_t reg_addr(input logic [15:0] offs);
		return {`MCU_PERIPH_PAGE, offs};
	endfunction

	// expected read data from the shadows and the driven inputs
	function automatic word_t ref_read(input word_t addr);
		word_t v;
		v = '0; // outside the page and unmapped offsets
		if (addr[31:16] == `MCU_PERIPH_PAGE) begin
			if (addr[15:12] == 4'h0) begin
				v = shadow_table[addr[11:2]];
			end else begin
				case (addr[15:0])
					`MCU_REG_SLOT_ID:     v = {16'h0, sh_id};
					`MCU_REG_SLOT_BRIDGE: v = sh_bridge;
					`MCU_REG_SLOT_LEN:    v = sh_len;
					`MCU_REG_SLOT_OFFS:   v = sh_offs;
					`MCU_REG_SLOT_CTRL:
						v = {27'h0, target_dataslot_ack, target_dataslot_done, target_dataslot_err};
					`MCU_REG_SYSCLK:      v = sh_sysclk;
					`MCU_REG_RESET:       v = {31'h0, sh_reset};
					`MCU_REG_IO_CTRL:     v = sh_io_ctrl & 32'h001E_FFFF; // selects, clk, dout
					`MCU_REG_IO_STAT:     v = {14'h0, exp_io_ack, io_wide, io_din};
					default:              v = '0;
				endcase
			end
		end
		return v;
	endfunction

	task automatic shadow_write(input word_t addr, input word_t data);
		if (addr[31:16] == `MCU_PERIPH_PAGE) begin
			if (addr[15:12] == 4'h0)
				shadow_table[addr[11:2]] = data;
			case (addr[15:0])
				`MCU_REG_SLOT_ID:     sh_id = data[15:0];
				`MCU_REG_SLOT_BRIDGE: sh_bridge = data;
				`MCU_REG_SLOT_LEN:    sh_len = data;
				`MCU_REG_SLOT_OFFS:   sh_offs = data;
				`MCU_REG_SYSCLK:      sh_sysclk = data;
				`MCU_REG_RESET:       sh_reset = data[0];
				`MCU_REG_IO_CTRL:     sh_io_ctrl = data;
				default: ;            // ctrl and timer keep no state
			endcase
		end
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_slot_id(input string name, input slot_id_t got, input slot_id_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic abort_run(input string what);
		$display("%s, bus FSM in %s", what, dbg_state.name());
		$display("Simulation failed");
		$finish;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(negedge clk_sys);
	endtask

	task automatic end_test(input string name, input int err0);
		tests++;
		if (errors == err0)
			$display("test %0d %s ok", tests, name);
		else
			$display("test %0d %s: %0d errors", tests, name, errors - err0);
	endtask

	// one access, req held until ack
	task automatic bus_access(input word_t addr, input word_t data, input logic [3:0] strb,
		output word_t rdata);
		int   n;
		int   exp_lat;
		logic got;
		n = 0;
		got = 1'b0;
		// negedges from req to ack, table reads wait one more for the RAM
		exp_lat = (addr[31:12] == 20'hFFFF0 && strb == 4'h0) ? 4 : 3;
		@(posedge clk_sys);
		cpu_req   <= 1'b1;
		cpu_addr  <= addr;
		cpu_wdata <= data;
		cpu_wstrb <= strb;
		while (!got && n < ACK_TIMEOUT) begin
			@(negedge clk_sys); // ack and rdata stable here
			got = cpu_ack;
			n++;
		end
		if (!got) begin
			abort_run("no cpu_ack within the timeout");
		end else begin
			check_word("cpu_ack latency", n, exp_lat);
			rdata     = cpu_rdata;
			ack_cycle = cycle;
			@(posedge clk_sys);
			cpu_req   <= 1'b0;
			cpu_wstrb <= 4'h0;
			@(negedge clk_sys);
			check_bit("cpu_ack", cpu_ack, 1'b0); // one cycle pulse
		end
	endtask

	task automatic bus_write(input word_t addr, input word_t data);
		word_t unused_rd;
		bus_access(addr, data, 4'hF, unused_rd);
		shadow_write(addr, data);
	endtask

	task automatic bus_read(input word_t addr, input logic cmp, output word_t rdata);
		cmp_en = cmp;
		bus_access(addr, '0, 4'h0, rdata);
		cmp_en = 1'b0;
	endtask

	// read compare, table address and pulse counting
	always @(negedge clk_sys) begin
		if (cpu_ack && cmp_en) begin
			check_word("cpu_rdata", cpu_rdata, ref_read(cpu_addr));
			if (cpu_addr[31:12] == 20'hFFFF0)
				check_word("datatable_addr", {22'h0, datatable_addr}, {22'h0, cpu_addr[11:2]});
		end
		if (datatable_wren)
			check_word("datatable_addr", {22'h0, datatable_addr}, {22'h0, cpu_addr[11:2]});
		if (target_dataslot_read)
			rd_pulses++;
		if (target_dataslot_write)
			wr_pulses++;
		if (io_strobe)
			strobes++;
	end

	initial begin : main
		word_t   data;
		word_t   rd;
		word_t   t0;
		word_t   t1;
		word_t   table_addrs [$];
		int      err0;
		int      base_rd;
		int      base_wr;
		int      n;
		int      c0;
		int      c_clr;
		int      delta;
		reset_n             <= 1'b0;
		cpu_req             <= 1'b0;
		cpu_addr            <= '0;
		cpu_wdata           <= '0;
		cpu_wstrb           <= 4'h0;
		target_dataslot_ack <= 1'b0;
		target_dataslot_done <= 1'b0;
		target_dataslot_err <= '0;
		io_din              <= '0;
		io_wide             <= 1'b0;
		sh_id = '0;
		sh_bridge = '0;
		sh_len = '0;
		sh_offs = '0;
		sh_sysclk = '0;    // divisor resets to zero
		sh_io_ctrl = '0;
		sh_reset = 1'b0;
		for (int i = 0; i < 1024; i++) begin
			ram[i] = fill_word(i);
			shadow_table[i] = fill_word(i);
		end
		repeat (8) @(posedge clk_sys);
		reset_n <= 1'b1;

		// 1: reset values, parameter registers
		err0 = errors;
		idle_cycles(1);
		check_bit("reset_out", reset_out, 1'b0);
		check_bit("target_dataslot_read", target_dataslot_read, 1'b0);
		check_bit("target_dataslot_write", target_dataslot_write, 1'b0);
		check_bit("io_strobe", io_strobe, 1'b0);
		check_bit("io_fpga", io_fpga, 1'b0);
		check_bit("io_uio", io_uio, 1'b0);
		check_bit("cpu_ack", cpu_ack, 1'b0);
		check_bit("datatable_wren", datatable_wren, 1'b0);
		for (int r = 0; r < 3; r++) begin
			bus_write(reg_addr(`MCU_REG_SLOT_ID), $random(seed));
			bus_write(reg_addr(`MCU_REG_SLOT_BRIDGE), $random(seed));
			bus_write(reg_addr(`MCU_REG_SLOT_LEN), $random(seed));
			bus_write(reg_addr(`MCU_REG_SLOT_OFFS), $random(seed));
			bus_write(reg_addr(`MCU_REG_RESET), $random(seed));
			bus_read(reg_addr(`MCU_REG_SLOT_ID), 1'b1, rd);
			bus_read(reg_addr(`MCU_REG_SLOT_BRIDGE), 1'b1, rd);
			bus_read(reg_addr(`MCU_REG_SLOT_LEN), 1'b1, rd);
			bus_read(reg_addr(`MCU_REG_SLOT_OFFS), 1'b1, rd);
			bus_read(reg_addr(`MCU_REG_RESET), 1'b1, rd);
			check_slot_id("target_dataslot_id", target_dataslot_id, sh_id);
			check_word("target_dataslot_bridgeaddr", target_dataslot_bridgeaddr, sh_bridge);
			check_word("target_dataslot_length", target_dataslot_length, sh_len);
			check_word("target_dataslot_slotoffset", target_dataslot_slotoffset, sh_offs);
			check_bit("reset_out", reset_out, sh_reset);
		end
		end_test("dataslot registers", err0);

		// 2: command pulses and live status
		err0 = errors;
		base_rd = rd_pulses;
		base_wr = wr_pulses;
		bus_write(reg_addr(`MCU_REG_SLOT_CTRL), 32'h1);
		idle_cycles(2);
		check_word("target_dataslot_read cycles", rd_pulses - base_rd, 1);
		check_word("target_dataslot_write cycles", wr_pulses - base_wr, 0);
		base_rd = rd_pulses;
		bus_write(reg_addr(`MCU_REG_SLOT_CTRL), 32'h2);
		idle_cycles(2);
		check_word("target_dataslot_read cycles", rd_pulses - base_rd, 0);
		check_word("target_dataslot_write cycles", wr_pulses - base_wr, 1);
		for (int i = 0; i < 6; i++) begin
			data = $random(seed);
			@(posedge clk_sys);
			target_dataslot_ack  <= data[0];
			target_dataslot_done <= data[1];
			target_dataslot_err  <= data[4:2];
			bus_read(reg_addr(`MCU_REG_SLOT_CTRL), 1'b1, rd);
		end
		end_test("command pulses and status", err0);

		// 3: data-table window, outside and unmapped reads
		err0 = errors;
		for (int i = 0; i < 12; i++) begin
			data = $random(seed);
			table_addrs.push_back({`MCU_PERIPH_PAGE, 4'h0, data[11:2], 2'b00});
			bus_write(table_addrs[i], $random(seed));
		end
		foreach (table_addrs[k])
			bus_read(table_addrs[k], 1'b1, rd);
		for (int i = 0; i < 4; i++) begin
			data = $random(seed);
			bus_read({`MCU_PERIPH_PAGE, 4'h0, data[11:2], 2'b00}, 1'b1, rd); // fill or written
		end
		bus_write(32'h0000_0100, $random(seed)); // program RAM space, dropped
		bus_read(32'h0000_0100, 1'b1, rd);
		bus_read(32'h1234_FF80, 1'b1, rd);
		bus_read(reg_addr(16'hFF94), 1'b1, rd);  // old UART divisor
		bus_read(reg_addr(16'h2000), 1'b1, rd);
		bus_read(reg_addr(16'hFFFC), 1'b1, rd);
		end_test("data table and zero reads", err0);

		// 4: timer with divisor 3, one count per 4 cycles
		err0 = errors;
		bus_write(reg_addr(`MCU_REG_SYSCLK), 32'd3);
		bus_write(reg_addr(`MCU_REG_TIMER), 32'd1);
		c_clr = ack_cycle;
		bus_read(reg_addr(`MCU_REG_SYSCLK), 1'b1, rd);
		bus_read(reg_addr(`MCU_REG_TIMER), 1'b0, t0);
		c0 = ack_cycle;
		checks++;
		if (t0 > (c0 - c_clr) / 4 + 1) begin
			errors++;
			$display("timer at %0d only %0d cycles after the clear", t0, c0 - c_clr);
		end
		n = 40 + ($random(seed) & 63);
		repeat (n) @(posedge clk_sys);
		bus_read(reg_addr(`MCU_REG_TIMER), 1'b0, t1);
		n = ack_cycle - c0;
		delta = t1 - t0;
		checks++;
		if (delta < n / 4 - 1 || delta > n / 4 + 1) begin
			errors++;
			$display("timer advanced by %0d over %0d cycles, out of range", delta, n);
		end
		end_test("millisecond timer", err0);

		// 5: selects, strobe and io_ack
		err0 = errors;
		for (int i = 0; i < 8; i++) begin
			data = $random(seed);
			data[20:18] = i[2:0];
			data[17] = 1'b0;
			bus_write(reg_addr(`MCU_REG_IO_CTRL), data);
			check_bit("io_fpga", io_fpga, data[18] & ~data[19]);
			check_bit("io_uio", io_uio, data[20] & ~data[19]);
			check_word("io_dout", {16'h0, io_dout}, {16'h0, data[15:0]});
			bus_read(reg_addr(`MCU_REG_IO_CTRL), 1'b1, rd);
		end
		data = $random(seed);
		@(posedge clk_sys);
		io_din  <= data[15:0];
		io_wide <= data[16];
		wait_hold <= 1'b1; // core busy, io_ack frozen
		strobes = 0;
		data = sh_io_ctrl;
		data[17] = 1'b1;
		bus_write(reg_addr(`MCU_REG_IO_CTRL), data);
		idle_cycles(2);
		check_word("io_strobe cycles", strobes, 1);
		check_bit("io_strobe", io_strobe, 1'b0);
		exp_io_ack = 1'b0;
		bus_read(reg_addr(`MCU_REG_IO_STAT), 1'b1, rd);
		wait_hold <= 1'b0;
		n = 0;
		rd = '0;
		while (!rd[17] && n < IO_TIMEOUT) begin
			bus_read(reg_addr(`MCU_REG_IO_STAT), 1'b0, rd);
			n++;
		end
		if (!rd[17]) begin
			abort_run("io_ack did not rise after io_wait dropped");
		end else begin
			exp_io_ack = 1'b1;
			bus_read(reg_addr(`MCU_REG_IO_STAT), 1'b1, rd);
			end_test("HPS IO port", err0);

			$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
			if (errors == 0)
				$display("Simulation passed");
			else
				$display("Simulation failed");
			$finish;
		end
	end

endmodule

`default_nettype wire
